//--- uart_line_pkg.sv
// Serial line definitions for 8N1 frames only; no parity bit is defined or expected
package uart_line_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Frame data
  ////////////////////////////////////////////////////////////////////////////

  // One data byte as carried on the line
  typedef logic [7:0] byte_t;

  ////////////////////////////////////////////////////////////////////////////
  // Frame geometry
  ////////////////////////////////////////////////////////////////////////////

  // Data bits per frame, sent least significant first
  localparam int unsigned DataBits = 8;

  // Start bit, data bits and a single stop bit
  localparam int unsigned FrameBits = 10;

endpackage

//--- uart_dbg_proto_pkg.sv
// Debug protocol codes and types; fields on the wire are least significant byte first
package uart_dbg_proto_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol field types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [63:0] addr_t;
  typedef logic [63:0] len_t;
  typedef logic [31:0] exit_code_t;

  // Bytes in an address or length field
  localparam int unsigned ArgBytes = 8;

  // Bytes in the exit code after EOC
  localparam int unsigned ExitBytes = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Command and reply codes
  ////////////////////////////////////////////////////////////////////////////

  localparam uart_line_pkg::byte_t CmdRead  = 8'h11;
  localparam uart_line_pkg::byte_t CmdWrite = 8'h12;
  localparam uart_line_pkg::byte_t CmdExec  = 8'h13;
  localparam uart_line_pkg::byte_t CodeAck  = 8'h06;
  localparam uart_line_pkg::byte_t CodeEot  = 8'h04;
  localparam uart_line_pkg::byte_t CodeEoc  = 8'h14;

  ////////////////////////////////////////////////////////////////////////////
  // Memory request
  ////////////////////////////////////////////////////////////////////////////

  // Address is wider than any memory here, the memory uses its low bits
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [15:0]          addr;
    uart_line_pkg::byte_t wdata;
  } mem_req_t;

endpackage

//--- uart_line_rx.sv
// 8N1 receiver sampling mid-bit; ClksPerBit should be at least 4, bad stop bits drop the byte
`timescale 1ns/100ps

module uart_line_rx #(
  parameter int unsigned ClksPerBit = 8
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 uart_rx_i,
  output logic                 rx_valid_o,
  output uart_line_pkg::byte_t rx_byte_o
);

  localparam int unsigned CntW = $clog2(ClksPerBit);
  localparam int unsigned BitW = $clog2(uart_line_pkg::DataBits);

  typedef enum logic [1:0] {
    RxIdle,
    RxStart,
    RxData,
    RxStop
  } rx_state_e;

  rx_state_e            state_q;
  logic                 rx_meta_q;
  logic                 rx_sync_q;
  logic                 rx_prev_q;
  logic [CntW-1:0]      clk_cnt_q;
  logic [BitW-1:0]      bit_cnt_q;
  logic                 valid_q;
  uart_line_pkg::byte_t shift_q;

  ////////////////////////////////////////////////////////////////////////////
  // Line synchronizer and edge history
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= uart_rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bit sampling
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= RxIdle;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      unique case (state_q)
        RxIdle: begin
          // Falling edge marks a start bit
          if (rx_prev_q && !rx_sync_q) begin
            state_q   <= RxStart;
            clk_cnt_q <= '0;
          end
        end
        RxStart: begin
          if (clk_cnt_q == CntW'(ClksPerBit / 2 - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            // A glitch that is gone by mid-bit is no start bit
            state_q   <= rx_sync_q ? RxIdle : RxData;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RxData: begin
          if (clk_cnt_q == CntW'(ClksPerBit - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == BitW'(uart_line_pkg::DataBits - 1)) begin
              state_q <= RxStop;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RxStop: begin
          if (clk_cnt_q == CntW'(ClksPerBit - 1)) begin
            clk_cnt_q <= '0;
            valid_q   <= rx_sync_q;
            state_q   <= RxIdle;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state_q == RxData && clk_cnt_q == CntW'(ClksPerBit - 1)) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

//--- uart_line_tx.sv
// 8N1 transmitter; tx_start_i is taken only while tx_busy_o is low, a frame lasts 10 bit times
`timescale 1ns/100ps

module uart_line_tx #(
  parameter int unsigned ClksPerBit = 8
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 tx_start_i,
  input  uart_line_pkg::byte_t tx_byte_i,
  output logic                 tx_busy_o,
  output logic                 uart_tx_o
);

  localparam int unsigned CntW = $clog2(ClksPerBit);
  localparam int unsigned BitW = $clog2(uart_line_pkg::FrameBits);

  logic                                   busy_q;
  logic                                   line_q;
  logic [CntW-1:0]                        clk_cnt_q;
  logic [BitW-1:0]                        bit_cnt_q;
  // Data and stop bits still to go out after the start bit
  logic [uart_line_pkg::FrameBits-2:0]    shift_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      line_q    <= 1'b1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        busy_q    <= 1'b1;
        line_q    <= 1'b0;
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
      end
    end else if (clk_cnt_q == CntW'(ClksPerBit - 1)) begin
      clk_cnt_q <= '0;
      if (bit_cnt_q == BitW'(uart_line_pkg::FrameBits - 1)) begin
        // Stop bit done, line is already high
        busy_q <= 1'b0;
      end else begin
        line_q    <= shift_q[0];
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy_q && tx_start_i) begin
      shift_q <= {1'b1, tx_byte_i};
    end else if (busy_q && clk_cnt_q == CntW'(ClksPerBit - 1)) begin
      shift_q <= {1'b1, shift_q[uart_line_pkg::FrameBits-2:1]};
    end
  end

  assign tx_busy_o = busy_q;
  assign uart_tx_o = line_q;

endmodule

//--- dbg_mem.sv
// Byte memory of 2**MemAddrWidth entries; addresses wrap, contents undefined until written
`timescale 1ns/100ps

module dbg_mem #(
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic                         clk,
  input  uart_dbg_proto_pkg::mem_req_t mem_req_i,
  output uart_line_pkg::byte_t         mem_rdata_o
);

  localparam int unsigned Depth = 2 ** MemAddrWidth;

  uart_line_pkg::byte_t    mem_q [Depth];
  uart_line_pkg::byte_t    rdata_q;
  logic [MemAddrWidth-1:0] idx;

  // Upper request address bits are ignored, which gives the wrap
  assign idx = mem_req_i.addr[MemAddrWidth-1:0];

  always_ff @(posedge clk) begin
    if (mem_req_i.req) begin
      if (mem_req_i.we) begin
        mem_q[idx] <= mem_req_i.wdata;
      end else begin
        // Read data holds until the next read
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign mem_rdata_o = rdata_q;

endmodule

//--- uart_dbg_engine.sv
// Debug command FSM; only length bits 15:0 count, unknown bytes ignored, EOC taken only when idle
`timescale 1ns/100ps

module uart_dbg_engine (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           rx_valid_i,
  input  uart_line_pkg::byte_t           rx_byte_i,
  input  logic                           tx_busy_i,
  output logic                           tx_start_o,
  output uart_line_pkg::byte_t           tx_byte_o,
  output uart_dbg_proto_pkg::mem_req_t   mem_req_o,
  input  uart_line_pkg::byte_t           mem_rdata_i,
  output logic                           exec_o,
  output uart_dbg_proto_pkg::addr_t      exec_addr_o,
  input  logic                           eoc_i,
  input  uart_dbg_proto_pkg::exit_code_t exit_code_i
);

  localparam int unsigned CntW = $clog2(uart_dbg_proto_pkg::ArgBytes);
  localparam logic [CntW-1:0] ArgLast  = CntW'(uart_dbg_proto_pkg::ArgBytes - 1);
  localparam logic [CntW-1:0] ExitLast = CntW'(uart_dbg_proto_pkg::ExitBytes - 1);

  typedef enum logic [3:0] {
    StIdle,
    StAddr,
    StLen,
    StAck,
    StRdReq,
    StRdSend,
    StWrData,
    StEot,
    StEoc,
    StExit
  } state_e;

  state_e                         state_q;
  logic [CntW-1:0]                cnt_q;
  uart_line_pkg::byte_t           cmd_q;
  uart_dbg_proto_pkg::addr_t      addr_q;
  uart_dbg_proto_pkg::len_t       len_q;
  uart_dbg_proto_pkg::exit_code_t exit_q;
  logic [15:0]                    ptr_q;
  logic                           len_zero;
  logic                           len_last;

  assign len_zero = (len_q[15:0] == 16'd0);
  assign len_last = (len_q[15:0] == 16'd1);

  ////////////////////////////////////////////////////////////////////////////
  // Reply strobes and memory requests
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_start_o      = 1'b0;
    tx_byte_o       = uart_dbg_proto_pkg::CodeAck;
    exec_o          = 1'b0;
    mem_req_o       = '0;
    mem_req_o.addr  = ptr_q;
    mem_req_o.wdata = rx_byte_i;
    unique case (state_q)
      StAck: begin
        tx_start_o = !tx_busy_i;
        // Exec is reported together with its ACK
        exec_o     = !tx_busy_i && (cmd_q == uart_dbg_proto_pkg::CmdExec);
      end
      StRdReq: mem_req_o.req = 1'b1;
      StRdSend: begin
        tx_start_o = !tx_busy_i;
        tx_byte_o  = mem_rdata_i;
      end
      StWrData: begin
        mem_req_o.req = rx_valid_i;
        mem_req_o.we  = 1'b1;
      end
      StEot: begin
        tx_start_o = !tx_busy_i;
        tx_byte_o  = uart_dbg_proto_pkg::CodeEot;
      end
      StEoc: begin
        tx_start_o = !tx_busy_i;
        tx_byte_o  = uart_dbg_proto_pkg::CodeEoc;
      end
      StExit: begin
        tx_start_o = !tx_busy_i;
        tx_byte_o  = exit_q[7:0];
      end
      default: ;
    endcase
  end

  assign exec_addr_o = addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= StIdle;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        StIdle: begin
          if (rx_valid_i) begin
            cnt_q <= '0;
            if (rx_byte_i == uart_dbg_proto_pkg::CodeAck) begin
              state_q <= StAck;
            end else if (rx_byte_i == uart_dbg_proto_pkg::CmdRead ||
                         rx_byte_i == uart_dbg_proto_pkg::CmdWrite ||
                         rx_byte_i == uart_dbg_proto_pkg::CmdExec) begin
              state_q <= StAddr;
            end
          end else if (eoc_i) begin
            state_q <= StEoc;
          end
        end
        StAddr: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == ArgLast) begin
              cnt_q   <= '0;
              // Exec carries no length field
              state_q <= (cmd_q == uart_dbg_proto_pkg::CmdExec) ? StAck : StLen;
            end
          end
        end
        StLen: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == ArgLast) begin
              cnt_q   <= '0;
              state_q <= StAck;
            end
          end
        end
        StAck: begin
          if (tx_start_o) begin
            if (cmd_q == uart_dbg_proto_pkg::CmdRead) begin
              state_q <= len_zero ? StEot : StRdReq;
            end else if (cmd_q == uart_dbg_proto_pkg::CmdWrite) begin
              state_q <= len_zero ? StEot : StWrData;
            end else begin
              state_q <= StIdle;
            end
          end
        end
        StRdReq: state_q <= StRdSend;
        StRdSend: begin
          if (tx_start_o) begin
            state_q <= len_last ? StEot : StRdReq;
          end
        end
        StWrData: begin
          if (rx_valid_i && len_last) begin
            state_q <= StEot;
          end
        end
        StEot: begin
          if (tx_start_o) begin
            state_q <= StIdle;
          end
        end
        StEoc: begin
          if (tx_start_o) begin
            cnt_q   <= '0;
            state_q <= StExit;
          end
        end
        StExit: begin
          if (tx_start_o) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == ExitLast) begin
              state_q <= StIdle;
            end
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command fields and data pointer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    unique case (state_q)
      StIdle: begin
        if (rx_valid_i) begin
          cmd_q <= rx_byte_i;
        end else if (eoc_i) begin
          exit_q <= exit_code_i;
        end
      end
      // Fields arrive LSB first, shift in from the top
      StAddr: if (rx_valid_i) addr_q <= {rx_byte_i, addr_q[63:8]};
      StLen:  if (rx_valid_i) len_q <= {rx_byte_i, len_q[63:8]};
      StAck:  ptr_q <= addr_q[15:0];
      StRdSend: begin
        if (tx_start_o) begin
          ptr_q        <= ptr_q + 16'd1;
          len_q[15:0]  <= len_q[15:0] - 16'd1;
        end
      end
      StWrData: begin
        if (rx_valid_i) begin
          ptr_q        <= ptr_q + 16'd1;
          len_q[15:0]  <= len_q[15:0] - 16'd1;
        end
      end
      StExit: if (tx_start_o) exit_q <= exit_q >> 8;
      default: ;
    endcase
  end

endmodule

//--- uart_dbg_top.sv
// UART debug target; ClksPerBit sets the baud rate, memory has 2**MemAddrWidth bytes that wrap
`timescale 1ns/100ps

module uart_dbg_top #(
  parameter int unsigned ClksPerBit   = 8,
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           uart_rx_i,
  output logic                           uart_tx_o,
  output logic                           exec_o,
  output uart_dbg_proto_pkg::addr_t      exec_addr_o,
  input  logic                           eoc_i,
  input  uart_dbg_proto_pkg::exit_code_t exit_code_i
);

  logic                         rx_valid;
  uart_line_pkg::byte_t         rx_byte;
  logic                         tx_start;
  uart_line_pkg::byte_t         tx_byte;
  logic                         tx_busy;
  uart_dbg_proto_pkg::mem_req_t mem_req;
  uart_line_pkg::byte_t         mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Serial line
  ////////////////////////////////////////////////////////////////////////////

  uart_line_rx #(
    .ClksPerBit ( ClksPerBit )
  ) u_rx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .uart_rx_i  ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_line_tx #(
    .ClksPerBit ( ClksPerBit )
  ) u_tx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .tx_start_i ( tx_start  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_busy_o  ( tx_busy   ),
    .uart_tx_o  ( uart_tx_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Command engine and memory
  ////////////////////////////////////////////////////////////////////////////

  uart_dbg_engine u_engine (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .rx_valid_i  ( rx_valid    ),
    .rx_byte_i   ( rx_byte     ),
    .tx_busy_i   ( tx_busy     ),
    .tx_start_o  ( tx_start    ),
    .tx_byte_o   ( tx_byte     ),
    .mem_req_o   ( mem_req     ),
    .mem_rdata_i ( mem_rdata   ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o ),
    .eoc_i       ( eoc_i       ),
    .exit_code_i ( exit_code_i )
  );

  dbg_mem #(
    .MemAddrWidth ( MemAddrWidth )
  ) u_mem (
    .clk         ( clk       ),
    .mem_req_i   ( mem_req   ),
    .mem_rdata_o ( mem_rdata )
  );

endmodule

//--- tb_clk_gen.sv
// Free-running 4 ns clock; reset is held high for ResetCycles rising edges, then released
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 8
) (
  output logic clk,
  output logic rst_o
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst_o <= 1'b0;
  end

endmodule

//--- uart_dbg_chk.sv
// Protocol checks for uart_dbg_top; assumes synchronous active-high reset, reports via $error
`timescale 1ns/100ps

module uart_dbg_chk (
  input logic clk,
  input logic rst_i,
  input logic exec_i,
  input logic tx_start_i,
  input logic tx_busy_i,
  input logic uart_tx_i
);

  // Exec is a single-cycle pulse
  exec_single_cycle: assert property (
    @(posedge clk) disable iff (rst_i) exec_i |=> !exec_i
  ) else $error("exec_o stayed high for more than one cycle");

  // Only back-pressure towards the engine, and the transmitter takes every strobe
  tx_start_when_free: assert property (
    @(posedge clk) disable iff (rst_i) tx_start_i |-> !tx_busy_i ##1 tx_busy_i
  ) else $error("tx_start strobed while tx_busy was high or not taken by the transmitter");

  // Line idles high once reset has been seen for a cycle
  tx_line_high_in_reset: assert property (
    @(posedge clk) (rst_i && $past(rst_i)) |-> uart_tx_i
  ) else $error("uart_tx_o low during reset");

endmodule

bind uart_dbg_top uart_dbg_chk u_chk (
  .clk        ( clk       ),
  .rst_i      ( rst_i     ),
  .exec_i     ( exec_o    ),
  .tx_start_i ( tx_start  ),
  .tx_busy_i  ( tx_busy   ),
  .uart_tx_i  ( uart_tx_o )
);

//--- tb_uart_dbg.sv
// Host-side model of the debug protocol at ClksPerBit 8; stops at the first mismatch
`timescale 1ns/100ps

module tb_uart_dbg;

  localparam int unsigned ClksPerBit   = 8;
  localparam int unsigned MemAddrWidth = 8;
  localparam int unsigned ClkPeriodNs  = 4;
  localparam int unsigned FrameCycles  = uart_line_pkg::FrameBits * ClksPerBit;
  localparam int unsigned QuietFrames  = 4;
  localparam int unsigned NumPairs     = 8;
  localparam int unsigned MaxLen       = 16;
  localparam int unsigned WrapLen      = 8;
  localparam int unsigned CmdBytes     = 1 + 2 * uart_dbg_proto_pkg::ArgBytes;

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog budget from the byte count of all tests
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned FillBytes  = CmdBytes + 256 + 2;
  localparam int unsigned PairBytes  = 2 * NumPairs * (CmdBytes + MaxLen + 2);
  localparam int unsigned WrapBytes  = 2 * (CmdBytes + WrapLen + 2);
  localparam int unsigned MiscBytes  = 2 + (2 + uart_dbg_proto_pkg::ArgBytes) +
                                       (1 + uart_dbg_proto_pkg::ExitBytes) + 3;
  localparam int unsigned QuietBytes = 2 * QuietFrames;
  localparam int unsigned TotalBytes = FillBytes + PairBytes + WrapBytes + MiscBytes +
                                       QuietBytes;
  localparam longint unsigned WatchdogNs =
    2 * longint'(TotalBytes) * FrameCycles * ClkPeriodNs + 1000 * ClkPeriodNs;

  logic                           clk;
  logic                           rst;
  logic                           uart_rx_i;
  logic                           uart_tx_o;
  logic                           exec_o;
  uart_dbg_proto_pkg::addr_t      exec_addr_o;
  logic                           eoc_i;
  uart_dbg_proto_pkg::exit_code_t exit_code_i;

  integer                    seed = 32'h29d2;
  int                        exec_count = 0;
  uart_dbg_proto_pkg::addr_t exec_seen;
  uart_line_pkg::byte_t      reply_q [$];
  uart_line_pkg::byte_t      model_mem [256];

  tb_clk_gen #(
    .ResetCycles ( 8 )
  ) u_clk_gen (
    .clk   ( clk ),
    .rst_o ( rst )
  );

  uart_dbg_top #(
    .ClksPerBit   ( ClksPerBit   ),
    .MemAddrWidth ( MemAddrWidth )
  ) UUT (
    .clk         ( clk         ),
    .rst_i       ( rst         ),
    .uart_rx_i   ( uart_rx_i   ),
    .uart_tx_o   ( uart_tx_o   ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o ),
    .eoc_i       ( eoc_i       ),
    .exit_code_i ( exit_code_i )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input uart_line_pkg::byte_t exp,
                            input uart_line_pkg::byte_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input uart_dbg_proto_pkg::addr_t exp,
                            input uart_dbg_proto_pkg::addr_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host side of the serial line
  ////////////////////////////////////////////////////////////////////////////

  // Start bit, LSB first data, stop bit
  task automatic send_byte(input uart_line_pkg::byte_t b);
    logic [uart_line_pkg::FrameBits-1:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < int'(uart_line_pkg::FrameBits); i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (ClksPerBit - 1) @(posedge clk);
    end
  endtask

  task automatic send_field(input logic [63:0] v, input int n);
    for (int i = 0; i < n; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  task automatic expect_reply(input string name, input uart_line_pkg::byte_t exp);
    int waited;
    waited = 0;
    while (reply_q.size() == 0) begin
      @(posedge clk);
      waited++;
      if (waited > int'(QuietFrames * FrameCycles)) begin
        $display("%s: no reply byte arrived on uart_tx_o", name);
        abort_run();
      end
    end
    check_byte(name, exp, reply_q.pop_front());
  endtask

  task automatic expect_quiet(input string name);
    repeat (QuietFrames * FrameCycles) @(posedge clk);
    if (reply_q.size() != 0) begin
      $display("%s: unexpected extra byte %h on uart_tx_o", name, reply_q[0]);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Protocol commands against the memory model
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_mem(input uart_dbg_proto_pkg::addr_t addr, input int len,
                           input string name);
    uart_line_pkg::byte_t data;
    logic [7:0]           idx;
    send_byte(uart_dbg_proto_pkg::CmdWrite);
    send_field(addr, int'(uart_dbg_proto_pkg::ArgBytes));
    send_field(64'(len), int'(uart_dbg_proto_pkg::ArgBytes));
    expect_reply(name, uart_dbg_proto_pkg::CodeAck);
    for (int i = 0; i < len; i++) begin
      data = uart_line_pkg::byte_t'($random(seed));
      // Memory wraps on the low 8 address bits
      idx = addr[7:0] + 8'(i);
      model_mem[idx] = data;
      send_byte(data);
    end
    expect_reply(name, uart_dbg_proto_pkg::CodeEot);
  endtask

  task automatic read_mem(input uart_dbg_proto_pkg::addr_t addr, input int len,
                          input string name);
    logic [7:0] idx;
    send_byte(uart_dbg_proto_pkg::CmdRead);
    send_field(addr, int'(uart_dbg_proto_pkg::ArgBytes));
    send_field(64'(len), int'(uart_dbg_proto_pkg::ArgBytes));
    expect_reply(name, uart_dbg_proto_pkg::CodeAck);
    for (int i = 0; i < len; i++) begin
      idx = addr[7:0] + 8'(i);
      expect_reply(name, model_mem[idx]);
    end
    expect_reply(name, uart_dbg_proto_pkg::CodeEot);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and watchdog
  ////////////////////////////////////////////////////////////////////////////

  // Deserialize uart_tx_o mid-bit on falling clock edges
  initial begin : tx_monitor
    uart_line_pkg::byte_t b;
    forever begin
      @(negedge clk);
      if (!rst && uart_tx_o === 1'b0) begin
        repeat (ClksPerBit / 2) @(negedge clk);
        for (int i = 0; i < int'(uart_line_pkg::DataBits); i++) begin
          repeat (ClksPerBit) @(negedge clk);
          b[i] = uart_tx_o;
        end
        repeat (ClksPerBit) @(negedge clk);
        if (uart_tx_o !== 1'b1) begin
          $display("Framing error: stop bit on uart_tx_o was not high");
          abort_run();
        end
        reply_q.push_back(b);
      end
    end
  end

  initial begin : exec_monitor
    forever begin
      @(negedge clk);
      if (!rst && exec_o === 1'b1) begin
        exec_count++;
        exec_seen = exec_addr_o;
      end
    end
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns before the tests finished", WatchdogNs);
    abort_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    uart_dbg_proto_pkg::addr_t      addr;
    uart_dbg_proto_pkg::exit_code_t code;
    uart_line_pkg::byte_t           junk;
    int                             len;
    uart_rx_i   = 1'b1;
    eoc_i       = 1'b0;
    exit_code_i = '0;
    @(posedge clk);
    while (rst) @(posedge clk);
    repeat (4) @(posedge clk);

    // Challenge answered by a single ACK
    send_byte(uart_dbg_proto_pkg::CodeAck);
    expect_reply("ack challenge", uart_dbg_proto_pkg::CodeAck);
    expect_quiet("ack challenge");

    // Whole memory gets known contents first
    write_mem('0, 256, "memory fill");

    for (int n = 0; n < int'(NumPairs); n++) begin
      addr = {$random(seed), $random(seed)};
      len  = 1 + int'({$random(seed)} % MaxLen);
      write_mem(addr, len, "random write");
      addr = {$random(seed), $random(seed)};
      len  = 1 + int'({$random(seed)} % MaxLen);
      read_mem(addr, len, "random read");
    end

    // Crossing address 255
    addr      = {$random(seed), $random(seed)};
    addr[7:0] = 8'hfc;
    write_mem(addr, int'(WrapLen), "wrap write");
    read_mem(addr, int'(WrapLen), "wrap read");

    addr       = {$random(seed), $random(seed)};
    exec_count = 0;
    send_byte(uart_dbg_proto_pkg::CmdExec);
    send_field(addr, int'(uart_dbg_proto_pkg::ArgBytes));
    expect_reply("exec", uart_dbg_proto_pkg::CodeAck);
    if (exec_count != 1) begin
      $display("exec: exec_o pulsed %0d times instead of once", exec_count);
      abort_run();
    end
    check_addr("exec", addr, exec_seen);

    code = $random(seed);
    @(posedge clk);
    eoc_i       <= 1'b1;
    exit_code_i <= code;
    @(posedge clk);
    eoc_i <= 1'b0;
    expect_reply("eoc", uart_dbg_proto_pkg::CodeEoc);
    for (int i = 0; i < int'(uart_dbg_proto_pkg::ExitBytes); i++) begin
      expect_reply("eoc exit code", code[8*i +: 8]);
    end

    // Unknown byte then a challenge
    do begin
      junk = uart_line_pkg::byte_t'($random(seed));
    end while (junk == uart_dbg_proto_pkg::CodeAck || junk == uart_dbg_proto_pkg::CmdRead ||
               junk == uart_dbg_proto_pkg::CmdWrite || junk == uart_dbg_proto_pkg::CmdExec);
    send_byte(junk);
    send_byte(uart_dbg_proto_pkg::CodeAck);
    expect_reply("unknown byte", uart_dbg_proto_pkg::CodeAck);
    expect_quiet("unknown byte");

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- uart_dbg_top.f
uart_line_pkg.sv
uart_dbg_proto_pkg.sv
uart_line_rx.sv
uart_line_tx.sv
dbg_mem.sv
uart_dbg_engine.sv
uart_dbg_top.sv
tb_clk_gen.sv
uart_dbg_chk.sv
tb_uart_dbg.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and fail when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_uart_dbg \
  -f uart_dbg_top.f -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
